/* hdl/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic               clk_i,
    input  logic               rst_i,
    // Processor side
    input  logic               p_strobe_i,
    input  logic               p_rw_i,
    input  logic               p_flush_i,
    input  dcache_pkg::word_t  p_addr_i,
    input  dcache_pkg::word_t  p_data_i,
    input  dcache_pkg::be_t    p_be_i,
    output dcache_pkg::word_t  p_data_o,
    output logic               p_ready_o,
    output logic               busy_flushing_o,
    // Memory side
    output logic               m_strobe_o,
    output logic               m_rw_o,
    output dcache_pkg::word_t  m_addr_o,
    output dcache_pkg::line_t  m_data_o,
    input  dcache_pkg::line_t  m_data_i,
    input  logic               m_ready_i,
    // From storage and replacement
    input  logic               hit_i,
    input  dcache_pkg::way_t   hit_way_i,
    input  dcache_pkg::line_t  hit_line_i,
    input  dcache_pkg::line_t  sel_line_i,
    input  dcache_pkg::tag_t   sel_tag_i,
    input  logic               sel_dirty_i,
    input  dcache_pkg::way_t   victim_way_i,
    // To storage and replacement
    output dcache_pkg::idx_t   index_o,
    output dcache_pkg::tag_t   tag_o,
    output dcache_pkg::way_t   sel_way_o,
    output logic               line_we_o,
    output dcache_pkg::way_t   wr_way_o,
    output dcache_pkg::line_t  wr_line_o,
    output logic               wr_dirty_o,
    output logic               dirty_clr_o,
    output logic               fill_o
);
    import dcache_pkg::*;

    dc_state_e state_q, state_d;

    // Registered request
    logic                     rw_q;
    tag_t                     tag_q;
    idx_t                     idx_q;
    logic [`DC_OFS_BITS-1:0]  ofs_q;
    word_t                    wdata_q;
    be_t                      be_q;
    line_t                    fill_buf_q;   // Line returned by memory

    logic [`DC_IDX_BITS:0]    walk_q;       // {way, set} during a flush
    logic                     walk_last;
    logic                     flush_act;
    logic                     flush_done;
    logic                     issue_wr;     // Start a line write-back
    logic                     issue_rd;     // Start a line read

    line_t                    merge_src;
    line_t                    merged_line;
    word_t                    merged_word;

    assign flush_act = (state_q == FLUSH_WALK) || (state_q == FLUSH_STEP);
    assign walk_last = &walk_q;

    // Walk ends on a clean last entry or on the last write-back ack
    assign flush_done = walk_last &&
                        (((state_q == FLUSH_WALK) && !sel_dirty_i) ||
                         ((state_q == FLUSH_STEP) && m_ready_i));

    // ========================================
    // State machine
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d  = state_q;
        issue_wr = 1'b0;
        issue_rd = 1'b0;
        case (state_q)
            IDLE:
                if (p_strobe_i)
                    state_d = LOOKUP;
                else if (p_flush_i)
                    state_d = FLUSH_WALK;
            LOOKUP:
                if (!hit_i)
                begin
                    issue_wr = sel_dirty_i;                       // Victim must go out first
                    issue_rd = !sel_dirty_i;
                    state_d  = sel_dirty_i ? WB_VICTIM : FILL;
                end
                else
                    state_d = IDLE;                               // Hit, done in one cycle
            WB_VICTIM:
                if (m_ready_i)
                    state_d = WB_DONE;
            WB_DONE:
            begin
                issue_rd = 1'b1;
                state_d  = FILL;
            end
            FILL:
                if (m_ready_i)
                    state_d = FILL_DONE;
            FILL_DONE:
                state_d = IDLE;
            FLUSH_WALK:
                if (sel_dirty_i)
                begin
                    issue_wr = 1'b1;
                    state_d  = FLUSH_STEP;
                end
                else if (walk_last)
                    state_d = IDLE;
            FLUSH_STEP:
                if (m_ready_i)
                    state_d = walk_last ? IDLE : FLUSH_WALK;
            default:
                state_d = IDLE;
        endcase
    end

    // ========================================
    // Request, fill buffer and flush walk
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if ((state_q == IDLE) && p_strobe_i)
        begin
            rw_q    <= p_rw_i;
            tag_q   <= p_addr_i[`DC_XLEN-1 -: `DC_TAG_BITS];
            idx_q   <= p_addr_i[`DC_OFS_BITS+2 +: `DC_IDX_BITS];
            ofs_q   <= p_addr_i[2 +: `DC_OFS_BITS];
            wdata_q <= p_data_i;
            be_q    <= p_be_i;
        end
        if ((state_q == FILL) && m_ready_i)
            fill_buf_q <= m_data_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i || (state_q == IDLE))
            walk_q <= '0;
        else if (((state_q == FLUSH_WALK) && !sel_dirty_i) ||
                 ((state_q == FLUSH_STEP) && m_ready_i))
            walk_q <= walk_q + 1'b1;                              // Set first, then way
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            busy_flushing_o <= 1'b0;
        else if ((state_q == IDLE) && p_flush_i && !p_strobe_i)
            busy_flushing_o <= 1'b1;
        else if (flush_done)
            busy_flushing_o <= 1'b0;
    end

    // ========================================
    // Memory port
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_rw_o     <= 1'b0;
        end
        else
        begin
            m_strobe_o <= issue_wr || issue_rd;                   // One-cycle pulse
            if (issue_wr || issue_rd)
                m_rw_o <= issue_wr;
            else if (m_ready_i)
                m_rw_o <= 1'b0;
        end
    end

    // Address and data held until the ack
    always_ff @(posedge clk_i)
    begin
        if (issue_wr)
        begin
            m_addr_o <= {sel_tag_i, index_o, {(`DC_OFS_BITS+2){1'b0}}};
            m_data_o <= sel_line_i;
        end
        else if (issue_rd)
            m_addr_o <= {tag_q, idx_q, {(`DC_OFS_BITS+2){1'b0}}};
    end

    // ========================================
    // Line update and processor response
    // ========================================
    assign merge_src = (state_q == FILL_DONE) ? fill_buf_q : hit_line_i;

    dcache_word_merge u_merge (
        .line_i   (merge_src),
        .offset_i (ofs_q),
        .wdata_i  (wdata_q),
        .be_i     (be_q),
        .word_o   (merged_word),
        .line_o   (merged_line)
    );

    assign index_o     = flush_act ? walk_q[`DC_IDX_BITS-1:0] : idx_q;
    assign tag_o       = tag_q;
    assign sel_way_o   = flush_act ? walk_q[`DC_IDX_BITS] : victim_way_i;
    assign line_we_o   = ((state_q == LOOKUP) && hit_i && rw_q) || (state_q == FILL_DONE);
    assign wr_way_o    = (state_q == LOOKUP) ? hit_way_i : victim_way_i;
    assign wr_line_o   = rw_q ? merged_line : fill_buf_q;      // Read fill stores raw line
    assign wr_dirty_o  = rw_q;
    assign dirty_clr_o = (state_q == FLUSH_STEP) && m_ready_i;
    assign fill_o      = (state_q == FILL_DONE);                // Advance the FIFO pointer

    assign p_ready_o = ((state_q == LOOKUP) && hit_i) || (state_q == FILL_DONE) || flush_done;
    assign p_data_o  = (!rw_q && (((state_q == LOOKUP) && hit_i) || (state_q == FILL_DONE))) ?
                       merged_word : '0;

endmodule

/* hdl/dcache_fifo_repl.sv */
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_fifo_repl (
    input  logic              clk_i,
    input  logic              rst_i,
    input  dcache_pkg::idx_t  index_i,
    input  logic              fill_i,         // A line was refilled in this set
    output dcache_pkg::way_t  victim_way_o
);
    import dcache_pkg::*;

    // One pointer per set, aimed at the oldest way
    way_t ptr_q [`DC_SETS];

    assign victim_way_o = ptr_q[index_i];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_SETS; s++)
                ptr_q[s] <= '0;                 // Way 0 is filled first
        end
        else if (fill_i)
        begin
            // Two ways, so the next oldest is simply the other one
            ptr_q[index_i] <= ptr_q[index_i] + 1'b1;
        end
    end

endmodule

/* hdl/dcache_pkg.sv */
`include "dcache_defs.svh"

package dcache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,           // Wait for a strobe or a flush
        LOOKUP,         // Tag compare on the registered request
        WB_VICTIM,      // Dirty victim going out to memory
        WB_DONE,        // Victim written, issue the line read
        FILL,           // Wait for the line from memory
        FILL_DONE,      // Write the fill into the victim way
        FLUSH_WALK,     // Inspect one way/set pair
        FLUSH_STEP      // Wait for a flush write-back
    } dc_state_e;

    typedef logic [`DC_XLEN-1:0]          word_t;
    typedef logic [`DC_LINE_BITS-1:0]     line_t;
    typedef logic [`DC_TAG_BITS-1:0]      tag_t;
    typedef logic [`DC_IDX_BITS-1:0]      idx_t;
    typedef logic [$clog2(`DC_WAYS)-1:0]  way_t;
    typedef logic [`DC_XLEN/8-1:0]        be_t;     // One enable per byte

endpackage

/* hdl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top (
    input  logic               clk_i,
    input  logic               rst_i,
    // Processor side
    input  logic               p_strobe_i,
    input  logic               p_rw_i,          // 1 = write
    input  logic               p_flush_i,
    input  dcache_pkg::word_t  p_addr_i,
    input  dcache_pkg::word_t  p_data_i,
    input  dcache_pkg::be_t    p_be_i,
    output dcache_pkg::word_t  p_data_o,
    output logic               p_ready_o,
    output logic               busy_flushing_o,
    // Memory side
    output logic               m_strobe_o,
    output logic               m_rw_o,          // 1 = write-back
    output dcache_pkg::word_t  m_addr_o,
    output dcache_pkg::line_t  m_data_o,
    input  dcache_pkg::line_t  m_data_i,
    input  logic               m_ready_i
);
    import dcache_pkg::*;

    // ========================================
    // Controller to storage
    // ========================================
    idx_t  index;
    tag_t  tag;
    way_t  sel_way;
    logic  line_we;
    way_t  wr_way;
    line_t wr_line;
    logic  wr_dirty;
    logic  dirty_clr;
    logic  fill;

    // Storage to controller
    logic  hit;
    way_t  hit_way;
    line_t hit_line;
    line_t sel_line;
    tag_t  sel_tag;
    logic  sel_dirty;
    way_t  victim_way;

    dcache_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .p_strobe_i      (p_strobe_i),
        .p_rw_i          (p_rw_i),
        .p_flush_i       (p_flush_i),
        .p_addr_i        (p_addr_i),
        .p_data_i        (p_data_i),
        .p_be_i          (p_be_i),
        .p_data_o        (p_data_o),
        .p_ready_o       (p_ready_o),
        .busy_flushing_o (busy_flushing_o),
        .m_strobe_o      (m_strobe_o),
        .m_rw_o          (m_rw_o),
        .m_addr_o        (m_addr_o),
        .m_data_o        (m_data_o),
        .m_data_i        (m_data_i),
        .m_ready_i       (m_ready_i),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .hit_line_i      (hit_line),
        .sel_line_i      (sel_line),
        .sel_tag_i       (sel_tag),
        .sel_dirty_i     (sel_dirty),
        .victim_way_i    (victim_way),
        .index_o         (index),
        .tag_o           (tag),
        .sel_way_o       (sel_way),
        .line_we_o       (line_we),
        .wr_way_o        (wr_way),
        .wr_line_o       (wr_line),
        .wr_dirty_o      (wr_dirty),
        .dirty_clr_o     (dirty_clr),
        .fill_o          (fill)
    );

    dcache_ways u_ways (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .index_i     (index),
        .tag_i       (tag),
        .sel_way_i   (sel_way),
        .line_we_i   (line_we),
        .wr_way_i    (wr_way),
        .wr_line_i   (wr_line),
        .wr_dirty_i  (wr_dirty),
        .dirty_clr_i (dirty_clr),
        .hit_o       (hit),
        .hit_way_o   (hit_way),
        .hit_line_o  (hit_line),
        .sel_line_o  (sel_line),
        .sel_tag_o   (sel_tag),
        .sel_dirty_o (sel_dirty)
    );

    dcache_fifo_repl u_repl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (index),
        .fill_i       (fill),
        .victim_way_o (victim_way)
    );

endmodule

/* hdl/dcache_ways.sv */
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_ways (
    input  logic               clk_i,
    input  logic               rst_i,
    input  dcache_pkg::idx_t   index_i,
    input  dcache_pkg::tag_t   tag_i,
    input  dcache_pkg::way_t   sel_way_i,     // Victim or flush way
    input  logic               line_we_i,
    input  dcache_pkg::way_t   wr_way_i,
    input  dcache_pkg::line_t  wr_line_i,
    input  logic               wr_dirty_i,
    input  logic               dirty_clr_i,
    output logic               hit_o,
    output dcache_pkg::way_t   hit_way_o,
    output dcache_pkg::line_t  hit_line_o,
    output dcache_pkg::line_t  sel_line_o,
    output dcache_pkg::tag_t   sel_tag_o,
    output logic               sel_dirty_o
);
    import dcache_pkg::*;

    // ========================================
    // Flop arrays, read combinationally
    // ========================================
    tag_t                 tag_q   [`DC_WAYS][`DC_SETS];
    line_t                data_q  [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0]  valid_q [`DC_WAYS];
    logic [`DC_SETS-1:0]  dirty_q [`DC_WAYS];

    logic [`DC_WAYS-1:0]  way_hit;

    // Tag compare in every way
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            way_hit[w] = valid_q[w][index_i] && (tag_q[w][index_i] == tag_i);
            if (way_hit[w])
                hit_way_o = way_t'(w);          // At most one way matches
        end
    end

    assign hit_o      = |way_hit;
    assign hit_line_o = data_q[hit_way_o][index_i];

    // Selected way feeds victim and flush write-backs
    assign sel_line_o  = data_q[sel_way_i][index_i];
    assign sel_tag_o   = tag_q[sel_way_i][index_i];
    assign sel_dirty_o = dirty_q[sel_way_i][index_i];

    // Payload storage
    always_ff @(posedge clk_i)
    begin
        if (line_we_i)
        begin
            tag_q[wr_way_i][index_i]  <= tag_i;
            data_q[wr_way_i][index_i] <= wr_line_i;
        end
    end

    // ========================================
    // Valid and dirty state
    // ========================================
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int w = 0; w < `DC_WAYS; w++)
            begin
                valid_q[w] <= '0;               // All lines invalid
                dirty_q[w] <= '0;
            end
        end
        else
        begin
            if (line_we_i)
            begin
                valid_q[wr_way_i][index_i] <= 1'b1;
                dirty_q[wr_way_i][index_i] <= wr_dirty_i;
            end
            if (dirty_clr_i)
                dirty_q[sel_way_i][index_i] <= 1'b0;  // Line now matches memory
        end
    end

endmodule

/* hdl/dcache_word_merge.sv */
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_word_merge (
    input  dcache_pkg::line_t         line_i,
    input  logic [`DC_OFS_BITS-1:0]   offset_i,   // Word within the line
    input  dcache_pkg::word_t         wdata_i,
    input  dcache_pkg::be_t           be_i,
    output dcache_pkg::word_t         word_o,
    output dcache_pkg::line_t         line_o
);
    import dcache_pkg::*;

    // Word w sits at bits [32*w +: 32], word 0 lowest
    always_comb
    begin
        word_o = '0;
        line_o = line_i;
        for (int w = 0; w < `DC_WORDS; w++)
        begin
            if (offset_i == w[`DC_OFS_BITS-1:0])
            begin
                word_o = line_i[w*`DC_XLEN +: `DC_XLEN];
                // Replace only the enabled bytes
                for (int b = 0; b < `DC_XLEN/8; b++)
                begin
                    if (be_i[b])
                        line_o[w*`DC_XLEN + b*8 +: 8] = wdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* include/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ========================================
// Cache geometry
// ========================================

`define DC_XLEN       32    // Processor word width
`define DC_LINE_BITS  128   // One cache line
`define DC_WORDS      4     // Words per line
`define DC_WAYS       2     // Associativity
`define DC_SETS       16    // Sets per way

// Address split, byte offset is the low 2 bits
`define DC_OFS_BITS   2     // Word offset inside a line
`define DC_IDX_BITS   4     // Set index
`define DC_TAG_BITS   24    // 32 - 4 - 2 - 2

`endif

/* list.f */
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_word_merge.sv
hdl/dcache_ways.sv
hdl/dcache_fifo_repl.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module dcache_tb -Mdir obj_dir -o dcache_sim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/dcache_sim

/* testbench/dcache_props.sv */
`timescale 1ns/100ps

module dcache_props (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               p_ready_i,
    input  logic               busy_flushing_i,
    input  logic               m_strobe_i,
    input  logic               m_rw_i,
    input  dcache_pkg::word_t  m_addr_i,
    input  logic               m_ready_i
);

    logic mem_pending_q;                    // Strobe sent, ack not seen yet

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            mem_pending_q <= 1'b0;
        else if (m_ready_i)
            mem_pending_q <= 1'b0;
        else if (m_strobe_i)
            mem_pending_q <= 1'b1;
    end

    // ========================================
    // Handshake rules
    // ========================================
    strobe_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_i |=> !m_strobe_i)
        else $error("m_strobe_o high for two cycles in a row");

    ready_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        p_ready_i |=> !p_ready_i)
        else $error("p_ready_o high for two cycles in a row");

    // Address held from the strobe up to the ack
    addr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_pending_q |-> $stable(m_addr_i))
        else $error("m_addr_o changed while a memory transfer was open");

    reset_quiet: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !(p_ready_i || busy_flushing_i || m_strobe_i || m_rw_i))
        else $error("control outputs not low right after reset");

endmodule

bind dcache_top dcache_props u_props (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .p_ready_i       (p_ready_o),
    .busy_flushing_i (busy_flushing_o),
    .m_strobe_i      (m_strobe_o),
    .m_rw_i          (m_rw_o),
    .m_addr_i        (m_addr_o),
    .m_ready_i       (m_ready_i)
);

/* testbench/dcache_tb.sv */
`timescale 1ns/100ps
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int MEM_LINES  = 256;        // 4 KB of backing store
    // About 40 requests of a dozen cycles and two 32-entry flush walks fit with wide margin
    localparam int WATCHDOG_CYCLES = 20000;

    logic   clk = 1'b0;
    logic   rst;
    logic   p_strobe, p_rw, p_flush;
    word_t  p_addr, p_wdata, p_rdata;
    be_t    p_be;
    logic   p_ready, busy_flushing;
    logic   m_strobe, m_rw, m_ready;
    word_t  m_addr;
    line_t  m_wdata, m_rdata;

    line_t  mem_lines [MEM_LINES];                  // Memory model contents
    word_t  ref_img   [MEM_LINES*`DC_WORDS];        // Expected word image
    word_t  wb_log    [$];                          // Write-back addresses
    int     rd_cnt, wr_cnt;
    integer seed;

    dcache_top UUT (
        .clk_i           (clk),
        .rst_i           (rst),
        .p_strobe_i      (p_strobe),
        .p_rw_i          (p_rw),
        .p_flush_i       (p_flush),
        .p_addr_i        (p_addr),
        .p_data_i        (p_wdata),
        .p_be_i          (p_be),
        .p_data_o        (p_rdata),
        .p_ready_o       (p_ready),
        .busy_flushing_o (busy_flushing),
        .m_strobe_o      (m_strobe),
        .m_rw_o          (m_rw),
        .m_addr_o        (m_addr),
        .m_data_o        (m_wdata),
        .m_data_i        (m_rdata),
        .m_ready_i       (m_ready)
    );

    initial
    begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ========================================
    // Checks and failure exit
    // ========================================
    task automatic report_failure(input string what);
        $display("Errors found");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        assert (got === exp)
        else
        begin
            $display("Error at %0t: %s read %h, expected %h", $time, what, got, exp);
            report_failure("wrong data value");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            $display("Error at %0t: %s", $time, what);
            report_failure(what);
        end
    endtask

    // Every word of one memory line against the image
    task automatic check_line(input int line_idx);
        for (int w = 0; w < `DC_WORDS; w++)
            check_word(mem_lines[line_idx][32*w +: 32], ref_img[line_idx*`DC_WORDS + w],
                       "memory word");
    endtask

    // ========================================
    // Memory model
    // ========================================
    initial
    begin : mem_model
        int     lat;
        word_t  addr;
        logic   rw;
        line_t  wdata;
        forever
        begin
            @(negedge clk);
            if (m_strobe === 1'b1)
            begin
                addr  = m_addr;
                rw    = m_rw;
                wdata = m_wdata;
                check_true(addr[3:0] == 4'h0, "memory address not line aligned");
                check_true(addr[31:12] == '0, "memory address outside the model");
                lat = 1 + ($random(seed) & 3);       // 1 to 4 cycles
                if (rw)
                begin
                    wr_cnt++;
                    wb_log.push_back(addr);
                end
                else
                    rd_cnt++;
                repeat (lat) @(posedge clk);
                #10;
                if (rw)
                    mem_lines[addr[11:4]] = wdata;
                else
                    m_rdata = mem_lines[addr[11:4]];
                m_ready = 1'b1;
                @(posedge clk);
                #10;
                m_ready = 1'b0;                     // One-cycle ack
            end
        end
    end

    // ========================================
    // Processor requests
    // ========================================
    // Returns at the negedge of the ready cycle
    // A hit gives lat 1
    task automatic wait_ready(output int lat);
        lat = 1;
        @(negedge clk);
        while (!p_ready)
        begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic cpu_read(input word_t addr, output word_t data, output int lat);
        @(posedge clk);
        #10;
        p_strobe = 1'b1;
        p_rw     = 1'b0;
        p_addr   = addr;
        @(posedge clk);
        #10;
        p_strobe = 1'b0;                            // Address stays put
        wait_ready(lat);
        data = p_rdata;
    endtask

    task automatic cpu_write(input word_t addr, input word_t data, input be_t be,
                             output int lat);
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
                ref_img[addr[11:2]][8*b +: 8] = data[8*b +: 8];
        end
        @(posedge clk);
        #10;
        p_strobe = 1'b1;
        p_rw     = 1'b1;
        p_addr   = addr;
        p_wdata  = data;
        p_be     = be;
        @(posedge clk);
        #10;
        p_strobe = 1'b0;
        wait_ready(lat);
    endtask

    task automatic cpu_flush(output int lat);
        @(posedge clk);
        #10;
        p_flush = 1'b1;
        @(posedge clk);
        #10;
        p_flush = 1'b0;
        lat = 1;
        @(negedge clk);
        check_true(busy_flushing, "busy_flushing_o low during the flush walk");
        while (!p_ready)
        begin
            @(negedge clk);
            lat++;
            check_true(busy_flushing, "busy_flushing_o low during the flush walk");
        end
        @(negedge clk);
        check_true(!busy_flushing, "busy_flushing_o still high after the flush");
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_read_miss_hit();
        word_t data;
        int    lat;
        int    rd0;
        int    wr0;
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        cpu_read(32'h0000_0124, data, lat);
        check_word(data, ref_img[32'h124 >> 2], "read miss");
        check_true(rd_cnt == rd0 + 1, "read miss did not make exactly one memory read");
        cpu_read(32'h0000_0128, data, lat);         // Other word of the same line
        check_word(data, ref_img[32'h128 >> 2], "read hit");
        check_true(lat == 1, "read of a resident line was not answered next cycle");
        check_true(rd_cnt == rd0 + 1 && wr_cnt == wr0, "read hit caused memory traffic");
    endtask

    task automatic test_byte_writes();
        word_t addrs [5] = '{32'h120, 32'h124, 32'h128, 32'h12C, 32'h124};
        be_t   bes   [5] = '{4'b0001, 4'b0011, 4'b0100, 4'b1100, 4'b1111};
        word_t data;
        int    lat;
        int    rd0;
        int    wr0;
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        for (int i = 0; i < 5; i++)
        begin
            cpu_write(addrs[i], $random(seed), bes[i], lat);
            check_true(lat == 1, "write to a resident line was not a hit");
        end
        for (int w = 0; w < `DC_WORDS; w++)
        begin
            cpu_read(32'h120 + 4*w, data, lat);
            check_word(data, ref_img[(32'h120 >> 2) + w], "byte write read-back");
        end
        check_true(rd_cnt == rd0 && wr_cnt == wr0, "write hits caused memory traffic");
    endtask

    task automatic test_write_allocate();
        word_t data;
        int    lat;
        int    rd0;
        int    wr0;
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        cpu_write(32'h0000_0358, $random(seed), 4'b0110, lat);
        check_true(rd_cnt == rd0 + 1, "write miss did not fetch the line once");
        cpu_read(32'h0000_0358, data, lat);
        check_word(data, ref_img[32'h358 >> 2], "merged word after allocate");
        check_true(lat == 1, "allocated line did not hit");
        cpu_read(32'h0000_0350, data, lat);
        check_word(data, ref_img[32'h350 >> 2], "untouched word after allocate");
        check_true(wr_cnt == wr0, "write allocate wrote to memory too early");
    endtask

    // Three tags in set 9 where the oldest one is dirty when the third arrives
    task automatic test_fifo_evict();
        word_t data;
        int    lat;
        int    rd0;
        int    wr0;
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        cpu_read(32'h0000_0190, data, lat);
        cpu_read(32'h0000_0290, data, lat);
        cpu_write(32'h0000_0194, $random(seed), 4'b1111, lat);
        check_true(lat == 1, "write to first line of set 9 missed");
        cpu_read(32'h0000_0390, data, lat);
        check_word(data, ref_img[32'h390 >> 2], "third line of set 9");
        check_true(wr_cnt == wr0 + 1, "dirty victim not written back exactly once");
        check_true(wb_log[$] == 32'h0000_0190, "write-back went to the wrong line");
        check_true(rd_cnt == rd0 + 3, "wrong number of line fills in set 9");
        check_line(32'h190 >> 4);
        cpu_read(32'h0000_0298, data, lat);         // Second line stays resident
        check_word(data, ref_img[32'h298 >> 2], "second line after eviction");
        check_true(lat == 1, "second line of set 9 was evicted");
    endtask

    task automatic test_flush();
        word_t expected [3] = '{32'h0000_0120, 32'h0000_0350, 32'h0000_0390};
        int    lat;
        int    rd0;
        int    wr0;
        int    n0;
        int    hits;
        cpu_write(32'h0000_0398, $random(seed), 4'b1111, lat);
        rd0 = rd_cnt;
        wr0 = wr_cnt;
        n0  = wb_log.size();
        cpu_flush(lat);
        check_true(lat >= 2*`DC_SETS, "flush finished before visiting every entry");
        check_true(wr_cnt == wr0 + 3, "flush wrote the wrong number of lines");
        check_true(rd_cnt == rd0, "flush read from memory");
        for (int e = 0; e < 3; e++)
        begin
            hits = 0;
            for (int i = n0; i < wb_log.size(); i++)
            begin
                if (wb_log[i] == expected[e])
                    hits++;
            end
            check_true(hits == 1, "dirty line not written back exactly once by flush");
        end
        for (int l = 0; l < MEM_LINES; l++)
            check_line(l);
        wr0 = wr_cnt;
        cpu_flush(lat);                             // Everything is clean now
        check_true(wr_cnt == wr0, "second flush wrote to memory");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial
    begin
        seed          = 81;
        rd_cnt        = 0;
        wr_cnt        = 0;
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_rw     = 1'b0;
        p_flush  = 1'b0;
        p_addr   = '0;
        p_wdata  = '0;
        p_be     = '0;
        m_ready  = 1'b0;
        m_rdata  = '0;
        for (int l = 0; l < MEM_LINES; l++)
        begin
            for (int w = 0; w < `DC_WORDS; w++)
            begin
                mem_lines[l][32*w +: 32]     = $random(seed);
                ref_img[l*`DC_WORDS + w]     = mem_lines[l][32*w +: 32];
            end
        end
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        test_read_miss_hit();
        test_byte_writes();
        test_write_allocate();
        test_fifo_evict();
        test_flush();
        $display("No errors");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error at %0t: watchdog expired before the tests finished", $time);
        report_failure("watchdog timeout, the cache stopped answering");
    end

endmodule
